// File: logic/llc_pkg.sv
/* cache geometry, address/line/way vector types and the controller state enum */

package llc_pkg;

    // geometry
    localparam int LLC_SETS  = 16;
    localparam int LLC_WAYS  = 2;
    localparam int ADDR_BITS = 12;
    localparam int LINE_BITS = 32;

    localparam int SET_BITS = $clog2(LLC_SETS);
    localparam int TAG_BITS = ADDR_BITS - SET_BITS;
    localparam int WAY_BITS = $clog2(LLC_WAYS);

    // word address, set in the low bits, tag above
    typedef logic [ADDR_BITS-1:0] addr_t;

    // one line holds one word
    typedef logic [LINE_BITS-1:0] line_t;

    typedef logic [SET_BITS-1:0] llc_set_t;
    typedef logic [TAG_BITS-1:0] llc_tag_t;
    typedef logic [WAY_BITS-1:0] llc_way_t;

    // controller sequencing
    typedef enum logic [2:0] {
        DECODE,
        READ_SET,
        LOOKUP,
        PROCESS,
        UPDATE
    } llc_state_e;

endpackage

// File: logic/llc_req_if.sv
/* request channel from input decoder to core */

`timescale 1ns/10ps

interface llc_req_if import llc_pkg::*; ();

    logic  valid;
    logic  ready;
    logic  write;
    addr_t addr;
    line_t data;

    modport dec (output valid, output write, output addr, output data, input ready);

    // core only pulls the ready line
    modport core (input valid, input write, input addr, input data, output ready);

endinterface

// File: logic/llc_array_if.sv
/* read and write ports of the tag, state and data arrays */

`timescale 1ns/10ps

interface llc_array_if import llc_pkg::*; ();

    // read request, data returns one cycle later
    logic     rd_en;
    llc_set_t set;

    // single way write plus evict pointer
    logic     wr_en;
    llc_set_t wr_set;
    llc_way_t wr_way;
    llc_tag_t wr_tag;
    logic     wr_valid;
    logic     wr_dirty;
    line_t    wr_data;
    llc_way_t wr_evict_way;

    // both ways of the read set
    llc_tag_t rd_tag   [LLC_WAYS];
    logic     rd_valid [LLC_WAYS];
    logic     rd_dirty [LLC_WAYS];
    line_t    rd_data  [LLC_WAYS];
    llc_way_t rd_evict_way;

    modport core (
        output rd_en, set, wr_en, wr_set, wr_way, wr_tag, wr_valid, wr_dirty, wr_data,
        output wr_evict_way,
        input  rd_tag, rd_valid, rd_dirty, rd_data, rd_evict_way
    );

    modport mem (
        input  rd_en, set, wr_en, wr_set, wr_way, wr_tag, wr_valid, wr_dirty, wr_data,
        input  wr_evict_way,
        output rd_tag, rd_valid, rd_dirty, rd_data, rd_evict_way
    );

endinterface

// File: logic/llc_input_decoder.sv
/* one-entry request register between the requester and the core */

`timescale 1ns/10ps

module llc_input_decoder import llc_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  req_valid_i,
    input  logic  req_write_i,
    input  addr_t req_addr_i,
    input  line_t req_data_i,
    output logic  req_ready_o,

    llc_req_if.dec req
);

    logic  full;
    logic  write_q;
    addr_t addr_q;
    line_t data_q;
    logic  take;
    logic  accept;

    // core empties the register this cycle
    assign take = full && req.ready;

    // free slot, or one being handed over right now
    assign req_ready_o = !full || req.ready;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (take) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            write_q <= req_write_i;
            addr_q  <= req_addr_i;
            data_q  <= req_data_i;
        end
    end

    assign req.valid = full;
    assign req.write = write_q;
    assign req.addr  = addr_q;
    assign req.data  = data_q;

endmodule

// File: logic/llc_localmem.sv
/* tag, valid, dirty and data arrays per way, evict-way pointer per set */

`timescale 1ns/10ps

module llc_localmem import llc_pkg::*; (
    input logic clk,
    input logic rst,

    llc_array_if.mem arr
);

    llc_tag_t              tag_mem   [LLC_WAYS][LLC_SETS];
    line_t                 data_mem  [LLC_WAYS][LLC_SETS];
    logic [LLC_SETS-1:0]   valid_q   [LLC_WAYS];
    logic [LLC_SETS-1:0]   dirty_q   [LLC_WAYS];
    llc_way_t              evict_q   [LLC_SETS];

    // state bits, cleared on reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            for (int s = 0; s < LLC_SETS; s++) begin
                evict_q[s] <= '0;
            end
        end else if (arr.wr_en) begin
            valid_q[arr.wr_way][arr.wr_set] <= arr.wr_valid;
            dirty_q[arr.wr_way][arr.wr_set] <= arr.wr_dirty;
            evict_q[arr.wr_set]             <= arr.wr_evict_way;
        end
    end

    always_ff @(posedge clk) begin
        if (arr.wr_en) begin
            tag_mem[arr.wr_way][arr.wr_set]  <= arr.wr_tag;
            data_mem[arr.wr_way][arr.wr_set] <= arr.wr_data;
        end
    end

    // synchronous read of both ways, held until the next rd_en
    always_ff @(posedge clk) begin
        if (arr.rd_en) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                arr.rd_tag[w]   <= tag_mem[w][arr.set];
                arr.rd_valid[w] <= valid_q[w][arr.set];
                arr.rd_dirty[w] <= dirty_q[w][arr.set];
                arr.rd_data[w]  <= data_mem[w][arr.set];
            end
            arr.rd_evict_way <= evict_q[arr.set];
        end
    end

endmodule

// File: logic/llc_core.sv
/* controller FSM: lookup, hit handling, dirty writeback, refill
   and the final array update */

`timescale 1ns/10ps

module llc_core import llc_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    llc_req_if.core   req,
    llc_array_if.core arr,

    output logic  rsp_valid_o,
    output line_t rsp_data_o,
    input  logic  rsp_ready_i,

    output logic  mem_req_valid_o,
    output logic  mem_req_write_o,
    output addr_t mem_req_addr_o,
    output line_t mem_req_data_o,
    input  logic  mem_req_ready_i,

    input  logic  mem_rsp_valid_i,
    input  line_t mem_rsp_data_i,
    output logic  mem_rsp_ready_o
);

    llc_state_e state, next_state;

    // latched request
    logic     wr_q;
    addr_t    addr_q;
    line_t    data_q;
    llc_set_t set_q;
    llc_tag_t tag_q;

    logic     hit_q;
    llc_way_t way_q;
    line_t    line_q;

    // PROCESS sub-flags
    logic wb_sent, fetch_sent, fill_done, rsp_sent;

    logic     hit;
    llc_way_t hit_way, vict_way;
    logic     need_wb, need_fetch, need_rsp;
    logic     wb_phase, fetch_phase;
    logic     rsp_fire, mem_req_fire, fill_fire;
    logic     process_done;

    assign set_q = addr_q[SET_BITS-1:0];
    assign tag_q = addr_q[ADDR_BITS-1:SET_BITS];

    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        vict_way = arr.rd_evict_way;
        for (int w = 0; w < LLC_WAYS; w++) begin
            if (arr.rd_valid[w] && arr.rd_tag[w] == tag_q) begin
                hit     = 1'b1;
                hit_way = llc_way_t'(w);
            end
        end
        // lowest invalid way wins over the pointer
        for (int w = LLC_WAYS - 1; w >= 0; w--) begin
            if (!arr.rd_valid[w]) begin
                vict_way = llc_way_t'(w);
            end
        end
    end

    // array read data holds through PROCESS, victim fields come from it
    assign need_wb    = !hit_q && arr.rd_valid[way_q] && arr.rd_dirty[way_q];
    assign need_fetch = !hit_q && !wr_q;
    assign need_rsp   = !wr_q;

    assign wb_phase    = need_wb && !wb_sent;
    assign fetch_phase = need_fetch && !wb_phase && !fetch_sent;

    assign mem_req_valid_o = (state == PROCESS) && (wb_phase || fetch_phase);
    assign mem_req_write_o = wb_phase;
    assign mem_req_addr_o  = wb_phase ? {arr.rd_tag[way_q], set_q} : addr_q;
    assign mem_req_data_o  = arr.rd_data[way_q];
    assign mem_req_fire    = mem_req_valid_o && mem_req_ready_i;

    assign mem_rsp_ready_o = (state == PROCESS) && fetch_sent && !fill_done;
    assign fill_fire       = mem_rsp_ready_o && mem_rsp_valid_i;

    assign rsp_valid_o = (state == PROCESS) && need_rsp && !rsp_sent &&
                         (!need_fetch || fill_done);
    assign rsp_data_o  = line_q;
    assign rsp_fire    = rsp_valid_o && rsp_ready_i;

    assign process_done = (!need_wb || wb_sent || (wb_phase && mem_req_fire)) &&
                          (!need_fetch || fill_done) &&
                          (!need_rsp || rsp_sent || rsp_fire);

    assign req.ready = (state == DECODE);

    always_comb begin
        next_state = state;
        case (state)
            DECODE:   if (req.valid) next_state = READ_SET;
            READ_SET: next_state = LOOKUP;
            LOOKUP:   next_state = PROCESS;
            PROCESS:  if (process_done) next_state = UPDATE;
            UPDATE:   next_state = DECODE;
            default:  next_state = DECODE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= DECODE;
            hit_q      <= 1'b0;
            way_q      <= '0;
            wb_sent    <= 1'b0;
            fetch_sent <= 1'b0;
            fill_done  <= 1'b0;
            rsp_sent   <= 1'b0;
        end else begin
            state <= next_state;
            if (state == LOOKUP) begin
                hit_q      <= hit;
                way_q      <= hit ? hit_way : vict_way;
                wb_sent    <= 1'b0;
                fetch_sent <= 1'b0;
                fill_done  <= 1'b0;
                rsp_sent   <= 1'b0;
            end else if (state == PROCESS) begin
                if (wb_phase && mem_req_fire) wb_sent <= 1'b1;
                if (fetch_phase && mem_req_fire) fetch_sent <= 1'b1;
                if (fill_fire) fill_done <= 1'b1;
                if (rsp_fire) rsp_sent <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid && req.ready) begin
            wr_q   <= req.write;
            addr_q <= req.addr;
            data_q <= req.data;
        end
        if (state == LOOKUP) begin
            line_q <= arr.rd_data[hit_way];
        end else if (fill_fire) begin
            line_q <= mem_rsp_data_i;
        end
    end

    assign arr.rd_en = (state == READ_SET);
    assign arr.set   = set_q;

    // write back the chosen way, pointer advances only on allocation
    assign arr.wr_en        = (state == UPDATE);
    assign arr.wr_set       = set_q;
    assign arr.wr_way       = way_q;
    assign arr.wr_tag       = tag_q;
    assign arr.wr_valid     = 1'b1;
    assign arr.wr_dirty     = wr_q || (hit_q && arr.rd_dirty[way_q]);
    assign arr.wr_data      = wr_q ? data_q : line_q;
    assign arr.wr_evict_way = hit_q ? arr.rd_evict_way : llc_way_t'(way_q + 1'b1);

endmodule

// File: logic/llc_top.sv
/* cache controller top: input decoder, arrays and core on plain ports */

`timescale 1ns/10ps

module llc_top import llc_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  req_valid_i,
    input  logic  req_write_i,
    input  addr_t req_addr_i,
    input  line_t req_data_i,
    output logic  req_ready_o,

    output logic  rsp_valid_o,
    output line_t rsp_data_o,
    input  logic  rsp_ready_i,

    output logic  mem_req_valid_o,
    output logic  mem_req_write_o,
    output addr_t mem_req_addr_o,
    output line_t mem_req_data_o,
    input  logic  mem_req_ready_i,

    input  logic  mem_rsp_valid_i,
    input  line_t mem_rsp_data_i,
    output logic  mem_rsp_ready_o
);

    llc_req_if   req_bus ();
    llc_array_if arr_bus ();

    llc_input_decoder u_input_decoder (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_write_i (req_write_i),
        .req_addr_i  (req_addr_i),
        .req_data_i  (req_data_i),
        .req_ready_o (req_ready_o),
        .req         (req_bus.dec)
    );

    llc_localmem u_localmem (
        .clk (clk),
        .rst (rst),
        .arr (arr_bus.mem)
    );

    llc_core u_core (
        .clk             (clk),
        .rst             (rst),
        .req             (req_bus.core),
        .arr             (arr_bus.core),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_data_o      (rsp_data_o),
        .rsp_ready_i     (rsp_ready_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_write_o (mem_req_write_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_data_o  (mem_req_data_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .mem_rsp_ready_o (mem_rsp_ready_o)
    );

endmodule

// File: tb/llc_mem_model.sv
/* backing memory model: stores write requests, answers reads after a random delay */

`timescale 1ns/10ps

module llc_mem_model import llc_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid_i,
    input  logic       req_write_i,
    input  addr_t      req_addr_i,
    input  line_t      req_data_i,
    output logic       req_ready_o,
    output logic       rsp_valid_o,
    output line_t      rsp_data_o,
    input  logic       rsp_ready_i,
    input  logic       stall_i,
    input  logic [2:0] delay_i
);

    line_t      mem [1 << ADDR_BITS];
    logic       busy;
    addr_t      pend_addr;
    logic [2:0] wait_cnt;
    logic       ready_nxt;
    logic       valid_nxt;
    line_t      data_nxt;

    initial begin
        req_ready_o = 1'b0;
        rsp_valid_o = 1'b0;
        rsp_data_o  = '0;
        busy        = 1'b0;
        pend_addr   = '0;
        wait_cnt    = '0;
        ready_nxt   = 1'b0;
        valid_nxt   = 1'b0;
        data_nxt    = '0;
    end

    always @(negedge clk) begin
        // outputs only move on the falling edge
        req_ready_o = ready_nxt;
        rsp_valid_o = valid_nxt;
        rsp_data_o  = data_nxt;
        // inputs settled, transfers of the next rising edge are known here
        #1;
        if (!rst) begin
            busy      = 1'b0;
            ready_nxt = 1'b0;
            valid_nxt = 1'b0;
        end else begin
            if (req_valid_i && req_ready_o) begin
                if (req_write_i) begin
                    mem[req_addr_i] = req_data_i;
                end else begin
                    busy      = 1'b1;
                    pend_addr = req_addr_i;
                    wait_cnt  = delay_i;
                end
            end
            if (rsp_valid_o && rsp_ready_i) begin
                busy      = 1'b0;
                valid_nxt = 1'b0;
            end else if (busy && !rsp_valid_o) begin
                if (wait_cnt == 0) begin
                    valid_nxt = 1'b1;
                    data_nxt  = mem[pend_addr];
                end else begin
                    wait_cnt--;
                end
            end
            ready_nxt = !busy && !stall_i;
        end
    end

endmodule

// File: tb/tb_llc_top.sv
/* testbench for the cache controller with random requests against a flat reference
   memory, and response, writeback and back-pressure checks */

`timescale 1ns/10ps

module tb_llc_top import llc_pkg::*; ();

    localparam int          NUM_REQ    = 400;
    localparam int          MAX_CYCLES = NUM_REQ * 60;
    localparam int          MEM_WORDS  = 1 << ADDR_BITS;
    localparam int          DRAIN_CYC  = 8;
    localparam logic [31:0] SEED       = 32'h6a6fec67;

    logic       clk = 1'b0;
    logic       rst;
    logic       req_valid_i;
    logic       req_write_i;
    addr_t      req_addr_i;
    line_t      req_data_i;
    logic       req_ready_o;
    logic       rsp_valid_o;
    line_t      rsp_data_o;
    logic       rsp_ready_i;
    logic       mem_req_valid_o;
    logic       mem_req_write_o;
    addr_t      mem_req_addr_o;
    line_t      mem_req_data_o;
    logic       mem_req_ready_i;
    logic       mem_rsp_valid_i;
    line_t      mem_rsp_data_i;
    logic       mem_rsp_ready_o;
    logic       mem_stall;
    logic [2:0] mem_delay;

    line_t       ref_mem [MEM_WORDS];
    bit          written [MEM_WORDS];
    line_t       exp_q [$];
    logic [31:0] lfsr_q;
    int          n_sent, n_accepted, n_reads, n_rsp, n_checks, n_errors, cycles;
    logic        req_taken, rsp_hold, mem_hold, mem_held_write;
    line_t       rsp_held, mem_held_data;
    addr_t       mem_held_addr;

    // youngest accepted request which may still sit in the decoder
    logic  last_wr;
    addr_t last_addr;
    line_t last_old_data;
    bit    last_old_written;

    always #10 clk = ~clk;

    llc_top u_dut (.*);

    llc_mem_model u_mem_model (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (mem_req_valid_o),
        .req_write_i (mem_req_write_o),
        .req_addr_i  (mem_req_addr_o),
        .req_data_i  (mem_req_data_o),
        .req_ready_o (mem_req_ready_i),
        .rsp_valid_o (mem_rsp_valid_i),
        .rsp_data_o  (mem_rsp_data_i),
        .rsp_ready_i (mem_rsp_ready_o),
        .stall_i     (mem_stall),
        .delay_i     (mem_delay)
    );

    function automatic line_t fill_word(input addr_t a);
        return {4'ha, a, 4'h5, ~a};
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_cond(input logic cond, input string what);
        n_checks++;
        assert (cond === 1'b1) else begin
            n_errors++;
            $display("ERROR t=%0t %s", $time, what);
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        int          idx;
        if (req_taken || !req_valid_i) begin
            draw_bits(2, r);
            req_valid_i = (n_sent < NUM_REQ) && (r[1:0] != 2'b00);
            if (req_valid_i) begin
                draw_bits(6, r);
                idx = int'(r % 48);
                // twelve tags in each of sets 2, 6, 10 and 14
                req_addr_i = {8'(idx / 4 * 19 + 5), 2'(idx % 4), 2'b10};
                draw_bits(1, r);
                // last request is a read so its response closes the run
                req_write_i = r[0] && (n_sent != NUM_REQ - 1);
                draw_bits(32, r);
                req_data_i = r;
                n_sent++;
            end
        end
        draw_bits(2, r);
        rsp_ready_i = (r[1:0] != 2'b00);
        draw_bits(2, r);
        mem_stall = (r[1:0] == 2'b00);
        draw_bits(3, r);
        mem_delay = r[2:0];
    endtask

    task automatic sample_outputs();
        line_t exp;
        bit    was_written;
        if (rsp_hold) begin
            check_cond(rsp_valid_o, "rsp_valid_o dropped before the response was taken");
            check_value("rsp_data_o", rsp_data_o, rsp_held);
        end
        if (mem_hold) begin
            check_cond(mem_req_valid_o, "mem_req_valid_o dropped before the memory took it");
            check_value("mem_req_write_o", 32'(mem_req_write_o), 32'(mem_held_write));
            check_value("mem_req_addr_o", 32'(mem_req_addr_o), 32'(mem_held_addr));
            check_value("mem_req_data_o", mem_req_data_o, mem_held_data);
        end
        if (rsp_valid_o && rsp_ready_i) begin
            n_rsp++;
            if (exp_q.size() == 0) begin
                check_cond(1'b0, "read response while no read was outstanding");
            end else begin
                check_value("rsp_data_o", rsp_data_o, exp_q.pop_front());
            end
        end
        if (mem_req_valid_o && mem_req_ready_i && mem_req_write_o) begin
            // a write to the victim still waiting in the decoder is not in the arrays yet
            if (last_wr && last_addr == mem_req_addr_o) begin
                exp         = last_old_data;
                was_written = last_old_written;
            end else begin
                exp         = ref_mem[mem_req_addr_o];
                was_written = written[mem_req_addr_o];
            end
            check_cond(was_written, "writeback of a line that was never written");
            check_value("mem_req_data_o", mem_req_data_o, exp);
        end
        if (req_valid_i && req_ready_o) begin
            n_accepted++;
            last_wr = req_write_i;
            if (req_write_i) begin
                last_addr           = req_addr_i;
                last_old_data       = ref_mem[req_addr_i];
                last_old_written    = written[req_addr_i];
                ref_mem[req_addr_i] = req_data_i;
                written[req_addr_i] = 1'b1;
            end else begin
                n_reads++;
                exp_q.push_back(ref_mem[req_addr_i]);
            end
        end
        req_taken      = req_valid_i && req_ready_o;
        rsp_hold       = rsp_valid_o && !rsp_ready_i;
        rsp_held       = rsp_data_o;
        mem_hold       = mem_req_valid_o && !mem_req_ready_i;
        mem_held_write = mem_req_write_o;
        mem_held_addr  = mem_req_addr_o;
        mem_held_data  = mem_req_data_o;
    endtask

    initial begin
        rst         = 1'b0;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_data_i  = '0;
        rsp_ready_i = 1'b0;
        mem_stall   = 1'b1;
        mem_delay   = '0;
        lfsr_q      = SEED;
        n_sent      = 0;
        n_accepted  = 0;
        n_reads     = 0;
        n_rsp       = 0;
        n_checks    = 0;
        n_errors    = 0;
        cycles      = 0;
        req_taken   = 1'b0;
        rsp_hold    = 1'b0;
        mem_hold    = 1'b0;
        last_wr     = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i]         = fill_word(addr_t'(i));
            written[i]         = 1'b0;
            u_mem_model.mem[i] = ref_mem[i];
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        check_cond(req_ready_o, "req_ready_o low in reset");
        check_cond(!rsp_valid_o, "rsp_valid_o high in reset");
        check_cond(!mem_req_valid_o, "mem_req_valid_o high in reset");
        check_cond(!mem_rsp_ready_o, "mem_rsp_ready_o high in reset");
        rst = 1'b1;

        while (!(n_accepted == NUM_REQ && exp_q.size() == 0) && cycles < MAX_CYCLES) begin
            @(negedge clk);
            drive_inputs();
            #1;
            sample_outputs();
            cycles++;
        end

        if (n_accepted == NUM_REQ && exp_q.size() == 0) begin
            // idle cycles so that stray responses still show up
            repeat (DRAIN_CYC) begin
                @(negedge clk);
                drive_inputs();
                #1;
                sample_outputs();
            end
            check_cond(req_ready_o, "req_ready_o low after the last response");
            check_cond(n_rsp == n_reads, "read response count differs from read count");
        end else begin
            n_errors++;
            $display("ERROR timeout after %0d cycles with %0d of %0d requests accepted",
                     cycles, n_accepted, NUM_REQ);
        end

        $display("checks %0d, errors %0d, reads %0d, responses %0d",
                 n_checks, n_errors, n_reads, n_rsp);
        if (n_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: llc_lite.f
logic/llc_pkg.sv
logic/llc_req_if.sv
logic/llc_array_if.sv
logic/llc_input_decoder.sv
logic/llc_localmem.sv
logic/llc_core.sv
logic/llc_top.sv
tb/llc_mem_model.sv
tb/tb_llc_top.sv

// File: Bender.yml
package:
  name: llc_lite

sources:
  - logic/llc_pkg.sv
  - logic/llc_req_if.sv
  - logic/llc_array_if.sv
  - logic/llc_input_decoder.sv
  - logic/llc_localmem.sv
  - logic/llc_core.sv
  - logic/llc_top.sv
  - target: test
    files:
      - tb/llc_mem_model.sv
      - tb/tb_llc_top.sv
